// File: design/aes_modes_settings.svh
`ifndef AES_MODES_SETTINGS_SVH
`define AES_MODES_SETTINGS_SVH

// Data path widths
`define AES_BLOCK_W 128
`define AES_KEY_W   128

// AES-128 round count
`define AES_ROUNDS  10

// Block mode codes
`define AES_MODE_W   3
`define AES_MODE_ECB 3'd0
`define AES_MODE_CBC 3'd1
`define AES_MODE_CFB 3'd2
`define AES_MODE_OFB 3'd3
`define AES_MODE_CTR 3'd4

`endif

// File: design/aes_pkg.sv
`include "aes_modes_settings.svh"

package aes_pkg;

  // One state word, per byte or per column
  // Byte 0 and column 0 sit at the top of the word
  typedef union packed {
    logic [0:`AES_BLOCK_W/8-1][7:0]   bytes;
    logic [0:`AES_BLOCK_W/32-1][31:0] cols;
  } aes_block_u;

  // Multiply by x in GF(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // General GF(2^8) product, shift and add
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    logic [7:0] y;
    p = 8'h00;
    x = a;
    y = b;
    for (int i = 0; i < 8; i++) begin
      if (y[0]) begin
        p = p ^ x;
      end
      x = xtime(x);
      y = y >> 1;
    end
    return p;
  endfunction

  // S-box from the field inverse and the affine map
  function automatic logic [7:0] sbox(input logic [7:0] x);
    logic [7:0] inv;
    logic [7:0] s;
    // x^127 by repeated square and multiply
    inv = x;
    for (int i = 0; i < 6; i++) begin
      inv = gf_mul(gf_mul(inv, inv), x);
    end
    // x^254 is the inverse, zero stays zero
    inv = gf_mul(inv, inv);
    s = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]};
    s = s ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    return s;
  endfunction

  // MixColumns on one column, row 0 in the top byte
  function automatic logic [31:0] mix_column(input logic [31:0] c);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = c[31:24];
    a1 = c[23:16];
    a2 = c[15:8];
    a3 = c[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

endpackage

// File: design/mode_decode.sv
`timescale 1ns/1ps
`include "aes_modes_settings.svh"

module mode_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic [`AES_BLOCK_W-1:0] data_in,
  input  logic [`AES_KEY_W-1:0]   key,
  input  logic [`AES_BLOCK_W-1:0] iv,
  input  logic [`AES_MODE_W-1:0]  mode,
  input  logic                   decrypt,
  input  logic                   first,
  input  logic                   busy,
  input  logic                   result_pending,
  input  logic [`AES_BLOCK_W-1:0] chain,
  output logic                   in_ready,
  output logic                   start,
  output logic [`AES_BLOCK_W-1:0] block_in,
  output logic [`AES_KEY_W-1:0]   key_out,
  output logic [`AES_BLOCK_W-1:0] held_data,
  output logic [`AES_MODE_W-1:0]  held_mode,
  output logic                   held_decrypt,
  output logic                   held_first
);

  logic                   accept;
  logic                   blk_first;
  logic                   stream_active;
  logic [`AES_MODE_W-1:0]  mode_q;
  logic [`AES_MODE_W-1:0]  eff_mode;
  logic                   dec_q;
  logic                   eff_dec;
  logic [`AES_KEY_W-1:0]   key_q;
  logic [`AES_BLOCK_W-1:0] prev;

  // ------------------------------------------------------------
  // Handshake and stream position
  // ------------------------------------------------------------
  // One block in flight, wait for core and output stage
  assign in_ready  = ~busy & ~result_pending;
  assign accept    = in_valid & in_ready;
  assign start     = accept;
  // No open stream means this block starts one
  assign blk_first = first | ~stream_active;

  // Stream settings come from the port on a first block
  assign eff_mode = blk_first ? mode : mode_q;
  assign eff_dec  = blk_first ? decrypt : dec_q;
  assign key_out  = blk_first ? key : key_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stream_active <= 1'b0;
      mode_q        <= `AES_MODE_ECB;
      dec_q         <= 1'b0;
    end else if (accept) begin
      stream_active <= 1'b1;
      mode_q        <= eff_mode;
      dec_q         <= eff_dec;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && blk_first) begin
      key_q <= key;
    end
  end

  // ------------------------------------------------------------
  // Cipher input selection
  // ------------------------------------------------------------
  // Chaining value, iv opens the stream
  assign prev = blk_first ? iv : chain;

  always_comb begin
    case (eff_mode)
      `AES_MODE_CBC: block_in = data_in ^ prev;
      `AES_MODE_CFB,
      `AES_MODE_OFB: block_in = prev;
      `AES_MODE_CTR: block_in = iv;
      default:       block_in = data_in;
    endcase
  end

  // Context for the output stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_mode    <= `AES_MODE_ECB;
      held_decrypt <= 1'b0;
      held_first   <= 1'b1;
    end else if (accept) begin
      held_mode    <= eff_mode;
      held_decrypt <= eff_dec;
      held_first   <= blk_first;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_data <= data_in;
    end
  end

  // ECB and CBC need the inverse cipher, not built here
  a_no_inverse: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> !(eff_dec && (eff_mode == `AES_MODE_ECB || eff_mode == `AES_MODE_CBC)));

  // A mode change only at a stream boundary
  a_mode_change: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && stream_active && mode != mode_q) |-> first);

endmodule

// File: design/key_expand.sv
`timescale 1ns/1ps
`include "aes_modes_settings.svh"

module key_expand (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic [`AES_KEY_W-1:0] key_out,
  input  logic                 busy,
  output aes_pkg::aes_block_u  round_key
);

  aes_pkg::aes_block_u rk_q;
  aes_pkg::aes_block_u rk_next;
  logic [7:0]          rcon_q;
  logic [31:0]         rot_word;
  logic [31:0]         sub_word;

  // RotWord on the last key word
  assign rot_word = {rk_q.cols[3][23:0], rk_q.cols[3][31:24]};

  // Next round key, one word feeding the next
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      sub_word[8*i +: 8] = aes_pkg::sbox(rot_word[8*i +: 8]);
    end
    rk_next.cols[0] = rk_q.cols[0] ^ sub_word ^ {rcon_q, 24'h000000};
    rk_next.cols[1] = rk_q.cols[1] ^ rk_next.cols[0];
    rk_next.cols[2] = rk_q.cols[2] ^ rk_next.cols[1];
    rk_next.cols[3] = rk_q.cols[3] ^ rk_next.cols[2];
  end

  // Round constant, doubles every step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rcon_q <= 8'h01;
    end else if (start) begin
      rcon_q <= 8'h01;
    end else if (busy) begin
      rcon_q <= aes_pkg::xtime(rcon_q);
    end
  end

  // Round 0 key on start, then one step per core cycle
  always_ff @(posedge clk) begin
    if (start) begin
      rk_q <= key_out;
    end else if (busy) begin
      rk_q <= rk_next;
    end
  end

  assign round_key = rk_q;

endmodule

// File: design/aes_round_core.sv
`timescale 1ns/1ps
`include "aes_modes_settings.svh"

module aes_round_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic [`AES_BLOCK_W-1:0] block_in,
  input  aes_pkg::aes_block_u    round_key,
  output logic                   busy,
  output logic                   done,
  output logic [`AES_BLOCK_W-1:0] cipher_out
);

  aes_pkg::aes_block_u state_q;
  aes_pkg::aes_block_u sub_st;
  aes_pkg::aes_block_u shift_st;
  aes_pkg::aes_block_u mix_st;
  aes_pkg::aes_block_u round_st;
  aes_pkg::aes_block_u ark0_st;
  logic [3:0]          round_q;
  logic                last_round;

  assign last_round = (round_q == 4'(`AES_ROUNDS));

  // ------------------------------------------------------------
  // Round function
  // ------------------------------------------------------------
  always_comb begin
    // SubBytes
    for (int i = 0; i < 16; i++) begin
      sub_st.bytes[i] = aes_pkg::sbox(state_q.bytes[i]);
    end
    // ShiftRows, row r moves left by r columns
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_st.bytes[4*c+r] = sub_st.bytes[4*((c+r)%4)+r];
      end
    end
    // MixColumns except on the last round, then AddRoundKey
    for (int c = 0; c < 4; c++) begin
      mix_st.cols[c]   = last_round ? shift_st.cols[c] : aes_pkg::mix_column(shift_st.cols[c]);
      round_st.cols[c] = mix_st.cols[c] ^ round_key.cols[c];
      ark0_st.cols[c]  = state_q.cols[c] ^ round_key.cols[c];
    end
  end

  // ------------------------------------------------------------
  // Round sequencing
  // ------------------------------------------------------------
  // Count 0 is the initial AddRoundKey, 1 to 10 the rounds
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      round_q <= 4'd0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        round_q <= 4'd0;
      end else if (busy) begin
        round_q <= round_q + 4'd1;
        if (last_round) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // State register, holds the ciphertext after the last round
  always_ff @(posedge clk) begin
    if (start) begin
      state_q <= block_in;
    end else if (busy) begin
      state_q <= (round_q == 4'd0) ? ark0_st : round_st;
    end
  end

  assign cipher_out = state_q;

  // Decode must wait for the core to finish
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

// File: design/mode_result.sv
`timescale 1ns/1ps
`include "aes_modes_settings.svh"

module mode_result (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   done,
  input  logic [`AES_BLOCK_W-1:0] cipher_out,
  input  logic [`AES_BLOCK_W-1:0] held_data,
  input  logic [`AES_MODE_W-1:0]  held_mode,
  input  logic                   held_decrypt,
  input  logic                   held_first,
  input  logic                   out_ready,
  output logic                   out_valid,
  output logic [`AES_BLOCK_W-1:0] data_out,
  output logic [`AES_BLOCK_W-1:0] chain,
  output logic                   result_pending
);

  logic [`AES_BLOCK_W-1:0] result;

  // Block modes pass the cipher, stream modes mask the data
  always_comb begin
    case (held_mode)
      `AES_MODE_ECB,
      `AES_MODE_CBC: result = cipher_out;
      default:       result = held_data ^ cipher_out;
    endcase
  end

  // ------------------------------------------------------------
  // Output handshake
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (done) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Held until taken by the sink
  always_ff @(posedge clk) begin
    if (done) begin
      data_out <= result;
    end
  end

  // Covers the done cycle before out_valid rises
  assign result_pending = done | out_valid;

  // ------------------------------------------------------------
  // Feedback for the next block
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (done) begin
      case (held_mode)
        `AES_MODE_CBC: chain <= result;
        `AES_MODE_CFB: chain <= held_decrypt ? held_data : result;
        `AES_MODE_OFB: chain <= cipher_out;
        default: begin
          // Non-chained stream drops old feedback
          if (held_first) begin
            chain <= '0;
          end
        end
      endcase
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(data_out)));

endmodule

// File: design/aes_modes_top.sv
`timescale 1ns/1ps
`include "aes_modes_settings.svh"

module aes_modes_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [`AES_BLOCK_W-1:0] data_in,
  input  logic [`AES_KEY_W-1:0]   key,
  input  logic [`AES_BLOCK_W-1:0] iv,
  input  logic [`AES_MODE_W-1:0]  mode,
  input  logic                   decrypt,
  input  logic                   first,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [`AES_BLOCK_W-1:0] data_out
);

  // Decode to core
  logic                   start;
  logic                   busy;
  logic [`AES_BLOCK_W-1:0] block_in;
  logic [`AES_KEY_W-1:0]   key_out;
  aes_pkg::aes_block_u    round_key;
  // Core to result
  logic                   done;
  logic [`AES_BLOCK_W-1:0] cipher_out;
  // Block context and feedback
  logic [`AES_BLOCK_W-1:0] held_data;
  logic [`AES_MODE_W-1:0]  held_mode;
  logic                   held_decrypt;
  logic                   held_first;
  logic [`AES_BLOCK_W-1:0] chain;
  logic                   result_pending;

  mode_decode u_mode_decode (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .data_in(data_in), .key(key), .iv(iv),
    .mode(mode), .decrypt(decrypt), .first(first),
    .busy(busy), .result_pending(result_pending), .chain(chain),
    .in_ready(in_ready), .start(start), .block_in(block_in), .key_out(key_out),
    .held_data(held_data), .held_mode(held_mode),
    .held_decrypt(held_decrypt), .held_first(held_first)
  );

  key_expand u_key_expand (
    .clk(clk), .rst_n(rst_n), .start(start), .key_out(key_out),
    .busy(busy), .round_key(round_key)
  );

  aes_round_core u_aes_round_core (
    .clk(clk), .rst_n(rst_n), .start(start), .block_in(block_in),
    .round_key(round_key), .busy(busy), .done(done), .cipher_out(cipher_out)
  );

  mode_result u_mode_result (
    .clk(clk), .rst_n(rst_n), .done(done), .cipher_out(cipher_out),
    .held_data(held_data), .held_mode(held_mode),
    .held_decrypt(held_decrypt), .held_first(held_first),
    .out_ready(out_ready), .out_valid(out_valid), .data_out(data_out),
    .chain(chain), .result_pending(result_pending)
  );

endmodule

// File: tb/tb_aes_modes.sv
`timescale 1ns/1ps
`include "aes_modes_settings.svh"

module tb_aes_modes;

  localparam int NUM_BLOCKS = 47;
  localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 30 + 200;

  logic                    clk;
  logic                    rst_n;
  logic                    in_valid;
  logic                    in_ready;
  logic [`AES_BLOCK_W-1:0] data_in;
  logic [`AES_KEY_W-1:0]   key;
  logic [`AES_BLOCK_W-1:0] iv;
  logic [`AES_MODE_W-1:0]  mode;
  logic                    decrypt;
  logic                    first;
  logic                    out_valid;
  logic                    out_ready;
  logic [`AES_BLOCK_W-1:0] data_out;

  // Reference model state for the open stream
  logic [`AES_MODE_W-1:0]  m_mode;
  logic                    m_dec;
  logic [`AES_KEY_W-1:0]   m_key;
  logic [`AES_BLOCK_W-1:0] m_chain;
  aes_pkg::aes_block_u     exp_q [$];
  aes_pkg::aes_block_u     got_q [$];
  int                      acc_q [$];
  logic [`AES_BLOCK_W-1:0] src_buf [0:3];
  logic [`AES_BLOCK_W-1:0] pt_buf [0:3];
  int                      cycle;
  logic                    stall_mode;
  logic                    hold_prev;
  aes_pkg::aes_block_u     data_prev;

  aes_modes_top u_aes_modes_top (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .in_ready(in_ready), .data_in(data_in), .key(key), .iv(iv),
    .mode(mode), .decrypt(decrypt), .first(first),
    .out_valid(out_valid), .out_ready(out_ready), .data_out(data_out)
  );

  // ------------------------------------------------------------
  // Failure reporting and compare tasks
  // ------------------------------------------------------------
  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_block(input string name, input aes_pkg::aes_block_u got,
                             input aes_pkg::aes_block_u exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------
  // Reference AES-128 forward cipher
  // ------------------------------------------------------------
  function automatic aes_pkg::aes_block_u aes_encrypt(input logic [127:0] k,
                                                      input logic [127:0] pt);
    logic [31:0]         w [0:43];
    logic [31:0]         t;
    logic [7:0]          rc;
    aes_pkg::aes_block_u s;
    aes_pkg::aes_block_u sb;
    // Full 44-word key schedule up front
    for (int i = 0; i < 4; i++) begin
      w[i] = k[127-32*i -: 32];
    end
    rc = 8'h01;
    for (int i = 4; i < 44; i++) begin
      t = w[i-1];
      if (i % 4 == 0) begin
        t = {aes_pkg::sbox(t[23:16]), aes_pkg::sbox(t[15:8]),
             aes_pkg::sbox(t[7:0]), aes_pkg::sbox(t[31:24])} ^ {rc, 24'h000000};
        rc = rc[7] ? ({rc[6:0], 1'b0} ^ 8'h1b) : {rc[6:0], 1'b0};
      end
      w[i] = w[i-4] ^ t;
    end
    s = pt ^ {w[0], w[1], w[2], w[3]};
    for (int rnd = 1; rnd <= 10; rnd++) begin
      for (int i = 0; i < 16; i++) begin
        sb.bytes[i] = aes_pkg::sbox(s.bytes[i]);
      end
      // Row r rotates left by r
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          s.bytes[4*c+r] = sb.bytes[4*((c+r)%4)+r];
        end
      end
      if (rnd < 10) begin
        for (int c = 0; c < 4; c++) begin
          s.cols[c] = aes_pkg::mix_column(s.cols[c]);
        end
      end
      s = s ^ {w[4*rnd], w[4*rnd+1], w[4*rnd+2], w[4*rnd+3]};
    end
    return s;
  endfunction

  // Chaining rule applied on top of the cipher
  task automatic expect_block(input logic [127:0] data, input logic [127:0] iv_v,
                              input logic [`AES_MODE_W-1:0] mode_v, input logic dec_v,
                              input logic [127:0] key_v, input logic first_v);
    logic [127:0] prev;
    logic [127:0] cin;
    logic [127:0] cout;
    logic [127:0] res;
    if (first_v) begin
      m_mode = mode_v;
      m_dec  = dec_v;
      m_key  = key_v;
    end
    prev = first_v ? iv_v : m_chain;
    case (m_mode)
      `AES_MODE_ECB: cin = data;
      `AES_MODE_CBC: cin = data ^ prev;
      `AES_MODE_CFB,
      `AES_MODE_OFB: cin = prev;
      default:       cin = iv_v;
    endcase
    cout = aes_encrypt(m_key, cin);
    res  = (m_mode == `AES_MODE_ECB || m_mode == `AES_MODE_CBC) ? cout : data ^ cout;
    if (m_mode == `AES_MODE_CBC) begin
      m_chain = res;
    end else if (m_mode == `AES_MODE_CFB) begin
      m_chain = m_dec ? data : res;
    end else if (m_mode == `AES_MODE_OFB) begin
      m_chain = cout;
    end
    exp_q.push_back(res);
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic send_block(input logic [127:0] data, input logic [127:0] iv_v,
                            input logic [`AES_MODE_W-1:0] mode_v, input logic dec_v,
                            input logic [127:0] key_v, input logic first_v);
    expect_block(data, iv_v, mode_v, dec_v, key_v, first_v);
    @(posedge clk);
    #2;
    in_valid = 1'b1;
    data_in  = data;
    iv       = iv_v;
    mode     = mode_v;
    decrypt  = dec_v;
    key      = key_v;
    first    = first_v;
    // in_ready only moves on a rising edge
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    first    = 1'b0;
  endtask

  // One stream from src_buf into got_q
  task automatic run_stream(input logic [`AES_MODE_W-1:0] mode_v, input logic dec_v,
                            input logic [127:0] key_v, input logic [127:0] iv_v,
                            input int n);
    got_q.delete();
    for (int i = 0; i < n; i++) begin
      // Host steps the counter block in CTR
      send_block(src_buf[i], (mode_v == `AES_MODE_CTR) ? iv_v + 128'(i) : iv_v,
                 mode_v, dec_v, key_v, i == 0);
    end
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  function automatic logic [127:0] rand_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // Encrypt then decrypt under the same key and iv
  task automatic round_trip(input logic [`AES_MODE_W-1:0] mode_v);
    logic [127:0] k;
    logic [127:0] v;
    k = rand_block();
    v = rand_block();
    for (int i = 0; i < 4; i++) begin
      pt_buf[i]  = rand_block();
      src_buf[i] = pt_buf[i];
    end
    run_stream(mode_v, 1'b0, k, v, 4);
    for (int i = 0; i < 4; i++) begin
      src_buf[i] = got_q[i];
    end
    run_stream(mode_v, 1'b1, k, v, 4);
    for (int i = 0; i < 4; i++) begin
      check_block("data_out", got_q[i], pt_buf[i]);
    end
  endtask

  // ------------------------------------------------------------
  // Clock, cycle count, timeout, sink
  // ------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycle, exp_q.size());
      abort_run();
    end
  end

  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      out_ready = stall_mode ? ($urandom % 4 == 0) : 1'b1;
    end
  end

  // Handshake monitor and compare on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_valid && in_ready) begin
        acc_q.push_back(cycle + 1);
      end
      // Latency of exactly 12 cycles
      if (acc_q.size() != 0 && cycle == acc_q[0] + 11) begin
        check_flag("out_valid", out_valid, 1'b0);
      end
      if (acc_q.size() != 0 && cycle == acc_q[0] + 12) begin
        check_flag("out_valid", out_valid, 1'b1);
        void'(acc_q.pop_front());
      end
      if (out_valid) begin
        check_flag("in_ready", in_ready, 1'b0);
      end
      // Stalled result must not move
      if (hold_prev) begin
        check_flag("out_valid", out_valid, 1'b1);
        check_block("data_out", data_out, data_prev);
      end
      hold_prev = out_valid && !out_ready;
      data_prev = data_out;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Output transfer seen with no block expected");
          abort_run();
        end
        check_block("data_out", data_out, exp_q.pop_front());
        got_q.push_back(data_out);
      end
    end
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(94));
    cycle      = 0;
    stall_mode = 1'b0;
    hold_prev  = 1'b0;
    m_chain    = '0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    data_in    = '0;
    key        = '0;
    iv         = '0;
    mode       = `AES_MODE_ECB;
    decrypt    = 1'b0;
    first      = 1'b0;
    // FIPS-197 appendix C.1
    check_block("aes_encrypt",
                aes_encrypt(128'h000102030405060708090a0b0c0d0e0f,
                            128'h00112233445566778899aabbccddeeff),
                128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);

    src_buf[0] = 128'h00112233445566778899aabbccddeeff;
    run_stream(`AES_MODE_ECB, 1'b0, 128'h000102030405060708090a0b0c0d0e0f, '0, 1);
    check_block("data_out", got_q[0], 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 3; i++) begin
        src_buf[i] = rand_block();
      end
      run_stream(`AES_MODE_ECB, 1'b0, rand_block(), '0, 3);
    end

    for (int i = 0; i < 4; i++) begin
      src_buf[i] = rand_block();
    end
    run_stream(`AES_MODE_CBC, 1'b0, rand_block(), rand_block(), 4);

    round_trip(`AES_MODE_CFB);
    round_trip(`AES_MODE_OFB);
    round_trip(`AES_MODE_CTR);

    // Random back-pressure from the sink
    stall_mode = 1'b1;
    round_trip(`AES_MODE_OFB);
    for (int i = 0; i < 4; i++) begin
      src_buf[i] = rand_block();
    end
    run_stream(`AES_MODE_ECB, 1'b0, rand_block(), '0, 4);
    stall_mode = 1'b0;

    repeat (3) @(negedge clk);
    if (exp_q.size() == 0 && acc_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Run ended with results still outstanding");
      $display("TEST RESULT: FAIL");
      $fatal(1, "outstanding results at end of run");
    end
  end

endmodule

// File: sources.f
+incdir+design
design/aes_pkg.sv
design/mode_decode.sv
design/key_expand.sv
design/aes_round_core.sv
design/mode_result.sv
design/aes_modes_top.sv
tb/tb_aes_modes.sv

// File: Makefile
TOP := tb_aes_modes

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
